/* project.f */
common/isaPkg.sv
common/pipePkg.sv
common/pipeIfs.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memWriteback.sv
logic/hazardUnit.sv
logic/pipelineTop.sv
tb/pipelineTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module pipelineTb -o simv || exit 1
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tb/pipelineTb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipelineTb;

    logic        clk;
    logic        rst;
    logic        progWe;
    logic [5:0]  progAddr;
    logic [31:0] progData;
    logic        wbValid;
    logic [4:0]  wbRd;
    logic [31:0] wbData;
    logic        storeValid;
    logic [31:0] storeAddr;
    logic [31:0] storeData;

    logic [31:0] prog [32];
    logic [31:0] progImm [32];
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [64];
    logic [4:0]  expRd [32];
    logic [31:0] expWb [32];
    logic [31:0] expStAddr [8];
    logic [31:0] expStData [8];
    int nProg, nWb, nSt, wbIdx, stIdx, sinceRst, errors, cycles;

    pipelineTop #(.imemDepth(64), .dmemDepth(64)) dut_i (
        .clk(clk), .rst(rst),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Instruction encoders for the supported formats.
    function automatic logic [31:0] encR(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(int imm, int rs1, logic [2:0] f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] encS(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(int imm, int rs2, int rs1);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // Register and immediate arithmetic as the ISA defines it.
    function automatic logic [31:0] aluRule(logic [2:0] f3, logic isSub, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'b000:  return isSub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 32'd0;
        endcase
    endfunction

    function automatic void expectWrite(logic [4:0] rd, logic [31:0] value);
        if (rd != 5'd0) begin
            modelRegs[rd] = value;
            expRd[nWb] = rd;
            expWb[nWb] = value;
            nWb++;
        end
    endfunction

    // Keeps each word next to the immediate it was built from.
    task automatic placeInstr(int idx, logic [31:0] word, int imm);
        prog[idx]    = word;
        progImm[idx] = imm;
    endtask

    task automatic loadProgram();
        placeInstr(0,  encI(5, 0, 3'b000, 1, 7'b0010011), 5);    // addi x1, x0, 5
        placeInstr(1,  encI(3, 1, 3'b000, 2, 7'b0010011), 3);    // addi x2, x1, 3
        placeInstr(2,  encR(7'b0000000, 2, 1, 3'b000, 3), 0);    // add  x3, x1, x2
        placeInstr(3,  encR(7'b0100000, 1, 3, 3'b000, 4), 0);    // sub  x4, x3, x1
        placeInstr(4,  encR(7'b0000000, 2, 3, 3'b111, 5), 0);    // and  x5, x3, x2
        placeInstr(5,  encR(7'b0000000, 1, 5, 3'b110, 6), 0);    // or   x6, x5, x1
        placeInstr(6,  encR(7'b0000000, 3, 4, 3'b010, 7), 0);    // slt  x7, x4, x3
        placeInstr(7,  encS(12, 7, 0), 12);                      // sw   x7, 12(x0)
        placeInstr(8,  encS(3, 6, 1), 3);                        // sw   x6, 3(x1)
        placeInstr(9,  encI(8, 0, 3'b010, 8, 7'b0000011), 8);    // lw   x8, 8(x0)
        placeInstr(10, encR(7'b0000000, 1, 8, 3'b000, 9), 0);    // add  x9, x8, x1
        placeInstr(11, encB(12, 9, 9), 12);                      // beq  x9, x9, +12
        placeInstr(12, encI(1, 0, 3'b000, 10, 7'b0010011), 1);   // Skipped.
        placeInstr(13, encI(2, 0, 3'b000, 11, 7'b0010011), 2);   // Skipped.
        placeInstr(14, encB(8, 1, 9), 8);                        // beq  x9, x1, +8
        placeInstr(15, encI(7, 0, 3'b000, 12, 7'b0010011), 7);   // addi x12, x0, 7
        placeInstr(16, encJ(12, 13), 12);                        // jal  x13, +12
        placeInstr(17, encI(9, 0, 3'b000, 14, 7'b0010011), 9);   // Skipped.
        placeInstr(18, encI(9, 0, 3'b000, 15, 7'b0010011), 9);   // Skipped.
        placeInstr(19, encI(5, 0, 3'b000, 0, 7'b0010011), 5);    // addi x0, x0, 5
        placeInstr(20, encR(7'b0000000, 12, 13, 3'b000, 16), 0); // add  x16, x13, x12
        placeInstr(21, encJ(0, 0), 0);                           // Self loop ends the program.
        placeInstr(22, 32'h0000_0013, 0);
        placeInstr(23, 32'h0000_0013, 0);
        nProg = 24;
    endtask

    // Runs the program one instruction at a time and records the event streams.
    task automatic buildExpected();
        logic [31:0] pc, next, ins, a, b, imm;
        logic done;
        int steps;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 64) begin
            ins  = prog[pc[6:2]];
            imm  = progImm[pc[6:2]];
            a    = modelRegs[ins[19:15]];
            b    = modelRegs[ins[24:20]];
            next = pc + 32'd4;
            case (ins[6:0])
                7'b0110011: expectWrite(ins[11:7], aluRule(ins[14:12], ins[30], a, b));
                7'b0010011: expectWrite(ins[11:7], aluRule(ins[14:12], 1'b0, a, imm));
                7'b0000011: expectWrite(ins[11:7], modelMem[(a + imm) >> 2]);
                7'b0100011: begin
                    expStAddr[nSt] = a + imm;
                    expStData[nSt] = b;
                    modelMem[(a + imm) >> 2] = b;
                    nSt++;
                end
                7'b1100011: begin
                    if (a == b) begin
                        next = pc + imm;
                    end
                end
                7'b1101111: begin
                    expectWrite(ins[11:7], pc + 32'd4);
                    next = pc + imm;
                    done = (imm == '0);
                end
                default: ;
            endcase
            pc = next;
            steps++;
        end
    endtask

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            sinceRst <= 0;
            wbIdx    <= 0;
            stIdx    <= 0;
        end else begin
            sinceRst <= sinceRst + 1;
            if (wbValid) begin
                wbIdx <= wbIdx + 1;
            end
            if (storeValid) begin
                stIdx <= stIdx + 1;
            end
        end
    end

    // Nothing can retire during reset or in the first four cycles after it.
    quietAfterReset: assert property (@(posedge clk)
        (!rst || sinceRst < 4) |-> !wbValid && !storeValid)
        else begin
            errors++;
            $display("mismatch at %0t: event output high before any instruction completed", $time);
        end

    wbMatches: assert property (@(posedge clk) disable iff (!rst)
        wbValid |-> wbIdx < nWb && wbRd == expRd[wbIdx] && wbData == expWb[wbIdx])
        else begin
            errors++;
            $display("mismatch at %0t: write-back x%0d = %h as entry %0d", $time,
                     $sampled(wbRd), $sampled(wbData), $sampled(wbIdx));
        end

    storeMatches: assert property (@(posedge clk) disable iff (!rst)
        storeValid |-> stIdx < nSt && storeAddr == expStAddr[stIdx]
                       && storeData == expStData[stIdx])
        else begin
            errors++;
            $display("mismatch at %0t: store %h to %h as entry %0d", $time,
                     $sampled(storeData), $sampled(storeAddr), $sampled(stIdx));
        end

    initial begin
        rst      = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        errors   = 0;
        nWb      = 0;
        nSt      = 0;
        loadProgram();
        buildExpected();
        for (int i = 0; i < nProg; i++) begin
            @(posedge clk);
            #1;
            progWe   = 1'b1;
            progAddr = i[5:0];
            progData = prog[i];
        end
        @(posedge clk);
        #1;
        progWe = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        cycles = 0;
        while ((wbIdx < nWb || stIdx < nSt) && cycles < 300) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cycles >= 300) begin
            errors++;
            $display("timeout: the program did not finish its write-backs and stores");
        end
        // A stray write-back after the last expected one still gets caught.
        repeat (20) @(posedge clk);
        #1;
        allSeen: assert (wbIdx == nWb && stIdx == nSt)
            else begin
                errors++;
                $display("wrong number of events: %0d write-backs and %0d stores", wbIdx, stIdx);
            end
        $display("errors %0d, write-backs %0d of %0d, stores %0d of %0d",
                 errors, wbIdx, nWb, stIdx, nSt);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/pipelineTop.sv */
`timescale 1ns/1ps
`default_nettype none

module pipelineTop #(
    parameter int imemDepth = 64,
    parameter int dmemDepth = 64
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         progWe,
    input  logic [$clog2(imemDepth)-1:0] progAddr,
    input  isaPkg::word_t                progData,
    output logic                         wbValid,
    output isaPkg::regIdx_t              wbRd,
    output isaPkg::word_t                wbData,
    output logic                         storeValid,
    output isaPkg::word_t                storeAddr,
    output isaPkg::word_t                storeData
);
    isaPkg::word_t instrD, pcD, pcPlus4D, pcTarget;
    logic pcSrc;

    idExIf   idEx ();
    exMemIf  exMem ();
    hazardIf hz (.clk(clk), .rst(rst));

    fetchStage #(.imemDepth(imemDepth)) fetchU (
        .clk(clk), .rst(rst),
        .stallF(hz.stallF), .flushD(hz.flushD),
        .pcSrc(pcSrc), .pcTarget(pcTarget),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .instrD(instrD), .pcD(pcD), .pcPlus4D(pcPlus4D)
    );

    decodeStage decodeU (
        .clk(clk), .rst(rst),
        .instrD(instrD), .pcD(pcD), .pcPlus4D(pcPlus4D),
        .hz(hz.decode), .idEx(idEx.source)
    );

    executeStage executeU (
        .clk(clk), .rst(rst),
        .idEx(idEx.sink), .hz(hz.execute), .exMem(exMem.source),
        .pcSrc(pcSrc), .pcTarget(pcTarget)
    );

    memWriteback #(.dmemDepth(dmemDepth)) memWbU (
        .clk(clk), .rst(rst),
        .exMem(exMem.sink), .hz(hz.memwb),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
    );

    hazardUnit hazardU (
        .hz(hz.hazard), .exMem(exMem.monitor)
    );

endmodule

`default_nettype wire

/* logic/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    hazardIf.hazard hz,
    exMemIf.monitor exMem
);
    logic lwStall;

    // Memory stage wins over writeback; x0 is never forwarded.
    function automatic pipePkg::fwdSel_e selectFwd(isaPkg::regIdx_t rs,
                                                   isaPkg::regIdx_t rdM, logic regWriteM,
                                                   isaPkg::regIdx_t rdW, logic regWriteW);
        if (rs != '0 && regWriteM && rdM == rs) begin
            return pipePkg::FWD_MEM;
        end
        if (rs != '0 && regWriteW && rdW == rs) begin
            return pipePkg::FWD_WB;
        end
        return pipePkg::FWD_REG;
    endfunction

    assign hz.forwardA   = selectFwd(hz.rs1E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);
    assign hz.forwardB   = selectFwd(hz.rs2E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);
    assign hz.aluResultM = exMem.aluResult;

    // A load in execute whose target is read in decode.
    assign lwStall = hz.resultSrcE == pipePkg::RES_MEM && hz.rdE != '0
                     && (hz.rdE == hz.rs1D || hz.rdE == hz.rs2D);

    assign hz.stallF = lwStall && !hz.pcSrc;
    assign hz.stallD = lwStall && !hz.pcSrc;
    assign hz.flushD = hz.pcSrc;
    assign hz.flushE = lwStall || hz.pcSrc;

    // A load-use stall lasts one cycle, the bubble behind it never stalls again.
    stallOneCycle: assert property (@(posedge hz.clk) disable iff (!hz.rst)
        hz.stallD |=> !hz.stallD);

endmodule

`default_nettype wire

/* logic/memWriteback.sv */
`timescale 1ns/1ps
`default_nettype none

module memWriteback #(
    parameter int dmemDepth = 64
) (
    input  logic            clk,
    input  logic            rst,
    exMemIf.sink            exMem,
    hazardIf.memwb          hz,
    output logic            wbValid,
    output isaPkg::regIdx_t wbRd,
    output isaPkg::word_t   wbData,
    output logic            storeValid,
    output isaPkg::word_t   storeAddr,
    output isaPkg::word_t   storeData
);
    localparam int addrW = $clog2(dmemDepth);

    isaPkg::word_t dmem [dmemDepth];
    isaPkg::word_t readDataM;
    isaPkg::word_t aluResultW, readDataW, pcPlus4W, resultW;
    isaPkg::regIdx_t rdW;
    logic regWriteW;
    pipePkg::resultSrc_e resultSrcW;

    // Word-addressed data array.
    assign readDataM = dmem[exMem.aluResult[addrW+1:2]];

    always_ff @(posedge clk) begin
        if (exMem.memWrite) begin
            dmem[exMem.aluResult[addrW+1:2]] <= exMem.writeData;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            aluResultW <= '0;
            readDataW  <= '0;
            pcPlus4W   <= '0;
            rdW        <= '0;
            regWriteW  <= 1'b0;
            resultSrcW <= pipePkg::RES_ALU;
        end else begin
            aluResultW <= exMem.aluResult;
            readDataW  <= readDataM;
            pcPlus4W   <= exMem.pcPlus4;
            rdW        <= exMem.rd;
            regWriteW  <= exMem.regWrite;
            resultSrcW <= exMem.resultSrc;
        end
    end

    always_comb begin
        case (resultSrcW)
            pipePkg::RES_MEM: resultW = readDataW;
            pipePkg::RES_PC4: resultW = pcPlus4W;
            default:          resultW = aluResultW;
        endcase
    end

    assign hz.rdM       = exMem.rd;
    assign hz.regWriteM = exMem.regWrite;
    assign hz.rdW       = rdW;
    assign hz.regWriteW = regWriteW;
    assign hz.resultW   = resultW;

    // Writes to x0 are dropped and never reported.
    assign wbValid    = regWriteW && rdW != '0;
    assign wbRd       = rdW;
    assign wbData     = resultW;
    assign storeValid = exMem.memWrite;
    assign storeAddr  = exMem.aluResult;
    assign storeData  = exMem.writeData;

    storeAligned: assert property (@(posedge clk) disable iff (!rst)
        exMem.memWrite |-> exMem.aluResult[1:0] == 2'b00);

endmodule

`default_nettype wire

/* logic/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic          clk,
    input  logic          rst,
    idExIf.sink           idEx,
    hazardIf.execute      hz,
    exMemIf.source        exMem,
    output logic          pcSrc,
    output isaPkg::word_t pcTarget
);
    isaPkg::word_t srcA, srcB, writeDataE, aluResultE;
    logic zeroE;

    function automatic isaPkg::word_t fwdMux(pipePkg::fwdSel_e sel, isaPkg::word_t regVal,
                                             isaPkg::word_t wbVal, isaPkg::word_t memVal);
        case (sel)
            pipePkg::FWD_WB:  return wbVal;
            pipePkg::FWD_MEM: return memVal;
            default:          return regVal;
        endcase
    endfunction

    assign srcA       = fwdMux(hz.forwardA, idEx.rd1, hz.resultW, hz.aluResultM);
    assign writeDataE = fwdMux(hz.forwardB, idEx.rd2, hz.resultW, hz.aluResultM);
    assign srcB       = idEx.aluSrc ? idEx.immExt : writeDataE;

    always_comb begin
        case (idEx.aluOp)
            pipePkg::ALU_SUB: aluResultE = srcA - srcB;
            pipePkg::ALU_AND: aluResultE = srcA & srcB;
            pipePkg::ALU_OR:  aluResultE = srcA | srcB;
            pipePkg::ALU_SLT: aluResultE = {31'd0, $signed(srcA) < $signed(srcB)};
            default:          aluResultE = srcA + srcB;
        endcase
    end

    assign zeroE    = (aluResultE == '0);
    // Branch and jal targets are both pc-relative.
    assign pcTarget = idEx.pc + idEx.immExt;
    assign pcSrc    = (idEx.branch && zeroE) || idEx.jump;

    assign hz.pcSrc      = pcSrc;
    assign hz.rs1E       = idEx.rs1;
    assign hz.rs2E       = idEx.rs2;
    assign hz.rdE        = idEx.rd;
    assign hz.resultSrcE = idEx.resultSrc;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            exMem.aluResult <= '0;
            exMem.writeData <= '0;
            exMem.pcPlus4   <= '0;
            exMem.rd        <= '0;
            exMem.regWrite  <= 1'b0;
            exMem.memWrite  <= 1'b0;
            exMem.resultSrc <= pipePkg::RES_ALU;
        end else begin
            exMem.aluResult <= aluResultE;
            exMem.writeData <= writeDataE;
            exMem.pcPlus4   <= idEx.pcPlus4;
            exMem.rd        <= idEx.rd;
            exMem.regWrite  <= idEx.regWrite;
            exMem.memWrite  <= idEx.memWrite;
            exMem.resultSrc <= idEx.resultSrc;
        end
    end

    // Forward selects come from the hazard unit and never use code 3.
    forwardCodeValid: assert property (@(posedge clk) disable iff (!rst)
        hz.forwardA != 2'b11 && hz.forwardB != 2'b11);

    // A flush of execute must show up as a bubble one cycle later.
    flushGivesBubble: assert property (@(posedge clk) disable iff (!rst)
        hz.flushE |=> !(idEx.regWrite || idEx.memWrite || idEx.branch || idEx.jump));

endmodule

`default_nettype wire

/* logic/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic          clk,
    input  logic          rst,
    input  isaPkg::word_t instrD,
    input  isaPkg::word_t pcD,
    input  isaPkg::word_t pcPlus4D,
    hazardIf.decode       hz,
    idExIf.source         idEx
);
    isaPkg::word_t regs [32];
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    isaPkg::regIdx_t rs1D, rs2D, rdD;
    isaPkg::word_t immI, immS, immB, immJ, immD;
    logic regWriteD, memWriteD, jumpD, branchD, aluSrcD;
    pipePkg::resultSrc_e resultSrcD;
    pipePkg::aluOp_e aluOpD;
    logic bubbleE;

    assign opcode = instrD[6:0];
    assign funct3 = instrD[14:12];
    assign funct7 = instrD[31:25];
    assign rs1D   = instrD[19:15];
    assign rs2D   = instrD[24:20];
    assign rdD    = instrD[11:7];

    assign hz.rs1D = rs1D;
    assign hz.rs2D = rs2D;

    // Sign-extended immediates.
    assign immI = {{20{instrD[31]}}, instrD[31:20]};
    assign immS = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
    assign immB = {{19{instrD[31]}}, instrD[31], instrD[7], instrD[30:25], instrD[11:8], 1'b0};
    assign immJ = {{11{instrD[31]}}, instrD[31], instrD[19:12], instrD[20], instrD[30:21], 1'b0};

    // Write early in the cycle: a same-cycle writeback is seen by the read.
    function automatic isaPkg::word_t readReg(isaPkg::regIdx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (hz.regWriteW && hz.rdW == idx) begin
            return hz.resultW;
        end
        return regs[idx];
    endfunction

    function automatic pipePkg::aluOp_e aluDecode(logic [2:0] f3, logic [6:0] f7, logic isReg);
        case (f3)
            isaPkg::F3_ADD: return (isReg && f7 == isaPkg::F7_SUB) ? pipePkg::ALU_SUB
                                                                  : pipePkg::ALU_ADD;
            isaPkg::F3_SLT: return pipePkg::ALU_SLT;
            isaPkg::F3_OR:  return pipePkg::ALU_OR;
            isaPkg::F3_AND: return pipePkg::ALU_AND;
            default:        return pipePkg::ALU_ADD;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (hz.regWriteW && hz.rdW != '0) begin
            regs[hz.rdW] <= hz.resultW;
        end
    end

    // Control decoder. Anything unknown stays a bubble.
    always_comb begin
        regWriteD  = 1'b0;
        memWriteD  = 1'b0;
        jumpD      = 1'b0;
        branchD    = 1'b0;
        aluSrcD    = 1'b0;
        resultSrcD = pipePkg::RES_ALU;
        aluOpD     = pipePkg::ALU_ADD;
        immD       = immI;
        case (opcode)
            isaPkg::OP_R: begin
                regWriteD = 1'b1;
                aluOpD    = aluDecode(funct3, funct7, 1'b1);
            end
            isaPkg::OP_IMM: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                aluOpD    = aluDecode(funct3, funct7, 1'b0);
            end
            isaPkg::OP_LOAD: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = pipePkg::RES_MEM;
            end
            isaPkg::OP_STORE: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immD      = immS;
            end
            isaPkg::OP_BRANCH: begin
                branchD = (funct3 == isaPkg::F3_BEQ);
                aluOpD  = pipePkg::ALU_SUB;
                immD    = immB;
            end
            isaPkg::OP_JAL: begin
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                resultSrcD = pipePkg::RES_PC4;
                immD       = immJ;
            end
            default: ;
        endcase
    end

    // Load-use stall and a taken redirect both leave a bubble in execute.
    assign bubbleE = hz.stallD || hz.flushD;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            idEx.rd1       <= '0;
            idEx.rd2       <= '0;
            idEx.pc        <= '0;
            idEx.pcPlus4   <= '0;
            idEx.immExt    <= '0;
            idEx.rs1       <= '0;
            idEx.rs2       <= '0;
            idEx.rd        <= '0;
            idEx.aluSrc    <= 1'b0;
            idEx.aluOp     <= pipePkg::ALU_ADD;
            idEx.regWrite  <= 1'b0;
            idEx.memWrite  <= 1'b0;
            idEx.jump      <= 1'b0;
            idEx.branch    <= 1'b0;
            idEx.resultSrc <= pipePkg::RES_ALU;
        end else begin
            idEx.rd1       <= readReg(rs1D);
            idEx.rd2       <= readReg(rs2D);
            idEx.pc        <= pcD;
            idEx.pcPlus4   <= pcPlus4D;
            idEx.immExt    <= immD;
            idEx.rs1       <= rs1D;
            idEx.rs2       <= rs2D;
            idEx.rd        <= rdD;
            idEx.aluSrc    <= aluSrcD;
            idEx.aluOp     <= aluOpD;
            idEx.regWrite  <= regWriteD && !bubbleE;
            idEx.memWrite  <= memWriteD && !bubbleE;
            idEx.jump      <= jumpD && !bubbleE;
            idEx.branch    <= branchD && !bubbleE;
            // Cleared too, or a bubble could look like a load and stall again.
            idEx.resultSrc <= bubbleE ? pipePkg::RES_ALU : resultSrcD;
        end
    end

endmodule

`default_nettype wire

/* logic/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter int imemDepth = 64
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         stallF,
    input  logic                         flushD,
    input  logic                         pcSrc,
    input  isaPkg::word_t                pcTarget,
    input  logic                         progWe,
    input  logic [$clog2(imemDepth)-1:0] progAddr,
    input  isaPkg::word_t                progData,
    output isaPkg::word_t                instrD,
    output isaPkg::word_t                pcD,
    output isaPkg::word_t                pcPlus4D
);
    localparam int addrW = $clog2(imemDepth);
    // Encoding of addi x0, x0, 0.
    localparam isaPkg::word_t nopInstr = 32'h0000_0013;

    isaPkg::word_t imem [imemDepth];
    isaPkg::word_t pcF;
    isaPkg::word_t pcPlus4F;
    isaPkg::word_t instrF;

    assign pcPlus4F = pcF + 32'd4;
    assign instrF   = imem[pcF[addrW+1:2]];

    // Program load port, used while the core sits in reset.
    always_ff @(posedge clk) begin
        if (progWe) begin
            imem[progAddr] <= progData;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pcF      <= '0;
            instrD   <= '0;
            pcD      <= '0;
            pcPlus4D <= '0;
        end else begin
            if (pcSrc) begin
                pcF <= pcTarget;
            end else if (!stallF) begin
                pcF <= pcPlus4F;
            end
            // Flush wins, so a redirect never keeps a wrong-path word.
            if (flushD) begin
                instrD   <= nopInstr;
                pcD      <= '0;
                pcPlus4D <= '0;
            end else if (!stallF) begin
                instrD   <= instrF;
                pcD      <= pcF;
                pcPlus4D <= pcPlus4F;
            end
        end
    end

endmodule

`default_nettype wire

/* common/pipeIfs.sv */
`timescale 1ns/1ps
`default_nettype none

// Registered decode outputs seen by execute.
interface idExIf;
    isaPkg::word_t rd1, rd2, pc, pcPlus4, immExt;
    isaPkg::regIdx_t rs1, rs2, rd;
    logic regWrite, memWrite, jump, branch, aluSrc;
    pipePkg::resultSrc_e resultSrc;
    pipePkg::aluOp_e aluOp;

    modport source (output rd1, rd2, pc, pcPlus4, immExt, rs1, rs2, rd,
                    regWrite, memWrite, jump, branch, aluSrc, resultSrc, aluOp);
    modport sink (input rd1, rd2, pc, pcPlus4, immExt, rs1, rs2, rd,
                  regWrite, memWrite, jump, branch, aluSrc, resultSrc, aluOp);
endinterface

// Execute/memory pipeline register contents.
interface exMemIf;
    isaPkg::word_t aluResult, writeData, pcPlus4;
    isaPkg::regIdx_t rd;
    logic regWrite, memWrite;
    pipePkg::resultSrc_e resultSrc;

    modport source (output aluResult, writeData, pcPlus4, rd, regWrite, memWrite, resultSrc);
    modport sink (input aluResult, writeData, pcPlus4, rd, regWrite, memWrite, resultSrc);
    modport monitor (input aluResult);
endinterface

// Hazard detection and forwarding traffic between the stages.
interface hazardIf (input logic clk, input logic rst);
    isaPkg::regIdx_t rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
    pipePkg::resultSrc_e resultSrcE;
    pipePkg::fwdSel_e forwardA, forwardB;
    logic pcSrc, regWriteM, regWriteW;
    logic stallF, stallD, flushD, flushE;
    isaPkg::word_t resultW, aluResultM;

    modport decode (output rs1D, rs2D, input stallD, flushD, rdW, regWriteW, resultW);
    modport execute (output rs1E, rs2E, rdE, resultSrcE, pcSrc,
                     input forwardA, forwardB, flushE, resultW, aluResultM);
    modport memwb (output rdM, regWriteM, rdW, regWriteW, resultW);
    modport hazard (input clk, rst, rs1D, rs2D, rs1E, rs2E, rdE, resultSrcE, pcSrc,
                    rdM, regWriteM, rdW, regWriteW,
                    output stallF, stallD, flushD, flushE, forwardA, forwardB, aluResultM);
endinterface

`default_nettype wire

/* common/pipePkg.sv */
`default_nettype none

package pipePkg;

    // ALU operation carried from decode to execute.
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOp_e;

    // Source of the value written back to the register file.
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } resultSrc_e;

    // Operand forwarding select; code 3 is unused.
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_WB  = 2'd1,
        FWD_MEM = 2'd2
    } fwdSel_e;

endpackage

`default_nettype wire

/* common/isaPkg.sv */
`default_nettype none

package isaPkg;

    // Data word, address and register index.
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;

    // Major opcodes of the supported subset.
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // funct3 codes.
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;

    // funct7 of sub; add has all zeros.
    localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage

`default_nettype wire
